//--- src/dbg_tx_config.svh
`ifndef DBG_TX_CONFIG_SVH
`define DBG_TX_CONFIG_SVH

// Frame marker characters.
`define DBG_START_CHAR 8'h24
`define DBG_SPLIT_CHAR 8'h2C
`define DBG_STOP_CHAR 8'h0A

// Clock cycles per serial bit.
`define DBG_BAUD_DIV 8

// Queue depths.
`define DBG_REQ_DEPTH 4
`define DBG_CHAR_DEPTH 4

`endif

//--- src/dbg_tx_pkg.sv
`default_nettype none

package dbg_tx_pkg;

	// One debug frame as pushed by the host.
	typedef struct packed {
		logic start_en;
		logic split_en;
		logic stop_en;
		logic [31:0] word;
	} frame_req_t;

	typedef logic [7:0] uart_char_t;

	// Formatter states.
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		START = 3'd1,
		DIGIT = 3'd2,
		SPLIT = 3'd3,
		STOP = 3'd4
	} frame_state_t;

endpackage

`default_nettype wire

//--- src/dbg_fifo.sv
`default_nettype none

module dbg_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
)(
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic push,
	input wire T push_data,
	input wire logic pop,
	output T pop_data,
	output logic full,
	output logic not_empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == FULL_COUNT);
	assign not_empty = (count != '0);
	// Head is visible in the same cycle as pop.
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Writer must respect full.
	assert property (@(posedge iCLOCK) disable iff (!inRESET) push |-> !full);
	// Reader must respect not_empty.
	assert property (@(posedge iCLOCK) disable iff (!inRESET) pop |-> not_empty);

endmodule

`default_nettype wire

//--- src/dbg_frame_fsm.sv
`default_nettype none

`include "dbg_tx_config.svh"

module dbg_frame_fsm import dbg_tx_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic req_valid,
	input wire frame_req_t req_head,
	output logic pop,
	output logic [2:0] digit_index,
	input wire uart_char_t digit_char,
	input wire logic char_full,
	output logic char_push,
	output uart_char_t char_data
);
	frame_state_t state;
	frame_state_t state_next;
	logic split_en;
	logic stop_en;
	logic last_digit;

	assign pop = (state == IDLE) && req_valid;
	// One character per cycle while the queue has room.
	assign char_push = (state != IDLE) && !char_full;
	assign last_digit = (digit_index == 3'd7);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (req_valid) begin
					state_next = req_head.start_en ? START : DIGIT;
				end
			end
			START: begin
				state_next = DIGIT;
			end
			DIGIT: begin
				if (last_digit) begin
					if (split_en) begin
						state_next = SPLIT;
					end else begin
						state_next = stop_en ? STOP : IDLE;
					end
				end
			end
			SPLIT: begin
				state_next = stop_en ? STOP : IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_comb begin
		case (state)
			START: char_data = `DBG_START_CHAR;
			SPLIT: char_data = `DBG_SPLIT_CHAR;
			STOP: char_data = `DBG_STOP_CHAR;
			default: char_data = digit_char;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			digit_index <= 3'd0;
			split_en <= 1'b0;
			stop_en <= 1'b0;
		end else if (pop) begin
			state <= state_next;
			digit_index <= 3'd0;
			split_en <= req_head.split_en;
			stop_en <= req_head.stop_en;
		end else if (char_push) begin
			state <= state_next;
			// Wraps back to 0 after the last digit.
			if (state == DIGIT) begin
				digit_index <= digit_index + 3'd1;
			end
		end
	end

	// Digit characters are upper-case hex.
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(char_push && state == DIGIT) |->
			(char_data inside {[8'h30:8'h39], [8'h41:8'h46]}));

	// Digit index is back at 0 between frames.
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(state == IDLE) |-> (digit_index == 3'd0));

endmodule

`default_nettype wire

//--- src/hex_ascii_encoder.sv
`default_nettype none

module hex_ascii_encoder import dbg_tx_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic load,
	input wire logic [31:0] word,
	input wire logic [2:0] digit_index,
	output uart_char_t digit_char
);
	logic [31:0] word_q;
	logic [4:0] bit_base;
	logic [3:0] nibble;

	// Index 0 selects the top nibble.
	assign bit_base = {3'd7 - digit_index, 2'b00};
	assign nibble = word_q[bit_base +: 4];

	// 8'h37 is 'A' minus ten.
	assign digit_char = (nibble > 4'd9) ? 8'h37 + {4'h0, nibble}
		: 8'h30 + {4'h0, nibble};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			word_q <= 32'h0;
		end else if (load) begin
			word_q <= word;
		end
	end

endmodule

`default_nettype wire

//--- src/baud_tick_timer.sv
`default_nettype none

module baud_tick_timer #(
	parameter int DIVISOR = 8
)(
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic restart,
	output logic tick
);
	localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIVISOR - 1);

	logic [CNT_W-1:0] count;

	// Tick lands DIVISOR cycles after restart, then every DIVISOR cycles.
	assign tick = (count == '0);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= RELOAD;
		end else if (restart || tick) begin
			count <= RELOAD;
		end else begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/uart_tx_shifter.sv
`default_nettype none

module uart_tx_shifter import dbg_tx_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic char_ready,
	input wire uart_char_t char_in,
	output logic char_pop,
	output logic restart,
	input wire logic tick,
	output logic txd
);
	logic [9:0] frame_q;
	logic [3:0] bit_cnt;
	logic busy;

	assign char_pop = !busy && char_ready;
	assign restart = char_pop;
	// Line follows the low end of the frame and rests high when idle.
	assign txd = frame_q[0];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			frame_q <= '1;
			bit_cnt <= 4'd0;
			busy <= 1'b0;
		end else if (char_pop) begin
			// Stop bit, data LSB first, start bit.
			frame_q <= {1'b1, char_in, 1'b0};
			bit_cnt <= 4'd0;
			busy <= 1'b1;
		end else if (busy && tick) begin
			frame_q <= {1'b1, frame_q[9:1]};
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
				bit_cnt <= 4'd0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// Start bit stays low until the first tick.
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(busy && bit_cnt == 4'd0) |-> !txd);

	// Line is back high after the stop bit's tick.
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(busy && tick && bit_cnt == 4'd9) |=> (!busy && txd));

endmodule

`default_nettype wire

//--- src/dbg_uart_tx_top.sv
`default_nettype none

`include "dbg_tx_config.svh"

module dbg_uart_tx_top import dbg_tx_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic req,
	input wire frame_req_t frame,
	output logic full,
	output logic txd
);
	logic req_valid;
	logic req_pop;
	frame_req_t req_head;
	logic [2:0] digit_index;
	uart_char_t digit_char;
	logic char_full;
	logic char_push;
	uart_char_t char_data;
	logic char_ready;
	logic char_pop;
	uart_char_t char_head;
	logic restart;
	logic tick;

	dbg_fifo #(
		.T(frame_req_t),
		.DEPTH(`DBG_REQ_DEPTH)
	) req_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.push(req),
		.push_data(frame),
		.pop(req_pop),
		.pop_data(req_head),
		.full(full),
		.not_empty(req_valid)
	);

	dbg_frame_fsm frame_fsm (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.req_valid(req_valid),
		.req_head(req_head),
		.pop(req_pop),
		.digit_index(digit_index),
		.digit_char(digit_char),
		.char_full(char_full),
		.char_push(char_push),
		.char_data(char_data)
	);

	// Word is captured on the same pulse that pops the frame.
	hex_ascii_encoder encoder (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.load(req_pop),
		.word(req_head.word),
		.digit_index(digit_index),
		.digit_char(digit_char)
	);

	dbg_fifo #(
		.T(uart_char_t),
		.DEPTH(`DBG_CHAR_DEPTH)
	) char_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.push(char_push),
		.push_data(char_data),
		.pop(char_pop),
		.pop_data(char_head),
		.full(char_full),
		.not_empty(char_ready)
	);

	baud_tick_timer #(
		.DIVISOR(`DBG_BAUD_DIV)
	) baud_timer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.tick(tick)
	);

	uart_tx_shifter shifter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.char_ready(char_ready),
		.char_in(char_head),
		.char_pop(char_pop),
		.restart(restart),
		.tick(tick),
		.txd(txd)
	);

endmodule

`default_nettype wire

//--- tests/uart_rx_model.sv
`default_nettype none

`include "dbg_tx_config.svh"

module uart_rx_model (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic txd,
	output logic rx_valid,
	output logic [7:0] rx_byte,
	output int frame_errors
);
	localparam int DIV = `DBG_BAUD_DIV;

	logic [7:0] shift;

	// Samples on the falling clock edge, away from line changes.
	initial begin
		rx_valid = 1'b0;
		rx_byte = 8'h00;
		frame_errors = 0;
		forever begin
			@(negedge iCLOCK);
			if (inRESET && !txd) begin
				// Move to the middle of the start bit.
				repeat (DIV / 2 - 1) @(negedge iCLOCK);
				if (!txd) begin
					for (int i = 0; i < 8; i++) begin
						repeat (DIV) @(negedge iCLOCK);
						shift[i] = txd;
					end
					repeat (DIV) @(negedge iCLOCK);
					if (!txd) begin
						frame_errors++;
						$display("Framing error at time %0t, the stop bit is low", $time);
					end
					rx_byte <= shift;
					rx_valid <= 1'b1;
					@(negedge iCLOCK);
					rx_valid <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_dbg_uart_tx.sv
`default_nettype none

`include "dbg_tx_config.svh"

module tb_dbg_uart_tx import dbg_tx_pkg::*; ();
	localparam int BIT_CYCLES = `DBG_BAUD_DIV;
	localparam int REQ_WAIT_LIMIT = 4000;

	logic iCLOCK;
	logic inRESET;
	logic req;
	frame_req_t frame;
	logic full;
	logic txd;
	logic rx_valid;
	logic [7:0] rx_byte;
	int frame_errors;

	logic [7:0] expected_q[$];
	logic [7:0] exp_byte;
	int errors;
	int expected_total;
	int received_count;
	int unsigned seed_value;
	bit timed_out;
	bit full_seen;

	dbg_uart_tx_top UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.req(req),
		.frame(frame),
		.full(full),
		.txd(txd)
	);

	uart_rx_model rx_model (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.txd(txd),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.frame_errors(frame_errors)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #20 iCLOCK = ~iCLOCK;
	end

	// Expected text of one frame.
	function automatic string frame_text(input frame_req_t f);
		string s;
		logic [3:0] nib;
		int v;
		s = "";
		if (f.start_en)
			s = {s, $sformatf("%c", `DBG_START_CHAR)};
		for (int i = 7; i >= 0; i--) begin
			nib = f.word[i*4 +: 4];
			v = (nib < 4'd10) ? int'("0") + nib : int'("A") + nib - 10;
			s = {s, $sformatf("%c", v)};
		end
		if (f.split_en)
			s = {s, $sformatf("%c", `DBG_SPLIT_CHAR)};
		if (f.stop_en)
			s = {s, $sformatf("%c", `DBG_STOP_CHAR)};
		return s;
	endfunction

	task automatic send_frame(input frame_req_t f);
		string s;
		int waited;
		waited = 0;
		@(negedge iCLOCK);
		while (full && waited < REQ_WAIT_LIMIT) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (full) begin
			$display("Timeout at %0t: full stayed high and the request was not taken", $time);
			errors++;
			timed_out = 1'b1;
		end else begin
			@(posedge iCLOCK);
			req <= 1'b1;
			frame <= f;
			s = frame_text(f);
			for (int i = 0; i < s.len(); i++)
				expected_q.push_back(s[i]);
			expected_total += s.len();
			@(posedge iCLOCK);
			req <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		int waited;
		int limit;
		waited = 0;
		limit = (expected_total - received_count + 2) * 10 * BIT_CYCLES + 100;
		@(negedge iCLOCK);
		while (received_count < expected_total && waited < limit) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (received_count < expected_total) begin
			$display("Timeout: only %0d of %0d characters arrived", received_count,
				expected_total);
			errors++;
			timed_out = 1'b1;
		end else begin
			// Past the end of the last stop bit.
			repeat (BIT_CYCLES) @(negedge iCLOCK);
			if (txd !== 1'b1) begin
				$display("[ERROR] %0t txd: expected 1, got %b", $time, txd);
				errors++;
			end
		end
	endtask

	// Compares each received character with the next expected one.
	always @(posedge iCLOCK) begin
		if (rx_valid) begin
			received_count++;
			if (expected_q.size() == 0) begin
				$display("Unexpected character 0x%02h at time %0t", rx_byte, $time);
				errors++;
			end else begin
				exp_byte = expected_q.pop_front();
				if (rx_byte !== exp_byte) begin
					$display("[ERROR] %0t rx_byte: expected 0x%02h, got 0x%02h", $time,
						exp_byte, rx_byte);
					errors++;
				end
			end
		end
	end

	always @(negedge iCLOCK) begin
		if (full === 1'b1)
			full_seen = 1'b1;
	end

	initial begin
		frame_req_t f;
		seed_value = $urandom(32'heb5b_c781);
		errors = 0;
		expected_total = 0;
		received_count = 0;
		timed_out = 1'b0;
		full_seen = 1'b0;
		inRESET = 1'b0;
		req = 1'b0;
		frame = '0;
		repeat (4) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(negedge iCLOCK);
		if (txd !== 1'b1) begin
			$display("[ERROR] %0t txd: expected 1, got %b", $time, txd);
			errors++;
		end
		if (full !== 1'b0) begin
			$display("[ERROR] %0t full: expected 0, got %b", $time, full);
			errors++;
		end
		// Every flag combination, one frame at a time.
		for (int m = 0; m < 8 && !timed_out; m++) begin
			f.start_en = m[2];
			f.split_en = m[1];
			f.stop_en = m[0];
			f.word = (m[0] ^ m[1] ^ m[2]) ? 32'h89AB_CDEF : 32'h0123_4567;
			send_frame(f);
			if (!timed_out)
				wait_drain();
		end
		// Random frames back to back.
		for (int n = 0; n < 24 && !timed_out; n++) begin
			f.word = $urandom;
			{f.start_en, f.split_en, f.stop_en} = 3'($urandom);
			send_frame(f);
		end
		if (!timed_out)
			wait_drain();
		if (!full_seen) begin
			$display("full never rose while requests were sent back to back");
			errors++;
		end
		if (frame_errors != 0) begin
			$display("The receiver saw %0d framing errors", frame_errors);
			errors += frame_errors;
		end
		$display("Errors: %0d, characters received: %0d, expected: %0d", errors,
			received_count, expected_total);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/dbg_tx_pkg.sv
src/dbg_fifo.sv
src/dbg_frame_fsm.sv
src/hex_ascii_encoder.sv
src/baud_tick_timer.sv
src/uart_tx_shifter.sv
src/dbg_uart_tx_top.sv
tests/uart_rx_model.sv
tests/tb_dbg_uart_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_dbg_uart_tx -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "Regression passed" sim.log; then
	echo "Simulation PASS"
	exit 0
fi
echo "Simulation FAIL"
exit 1
